// File: filelist.f
rtl/socBusPkg.sv
rtl/busArbiter.sv
rtl/busMemory.sv
rtl/gpioSlave.sv
rtl/ramDmaCi.sv
rtl/or1420Soc.sv
verif/busArbiter_assert.sv
verif/socTb.sv

// File: rtl/busArbiter.sv
`timescale 1ns/1ps

module busArbiter (
  input  logic                              s_systemClock,
  input  logic                              s_reset,
  input  logic [socBusPkg::nrOfMasters-1:0] busRequests,
  output logic [socBusPkg::nrOfMasters-1:0] busGrants,
  input  socBusPkg::busSignals_t            sharedBus,
  output socBusPkg::busSignals_t            arbiterBus
);

  logic [socBusPkg::nrOfMasters-1:0]               priorityGrant;
  logic [$clog2(socBusPkg::busTimeoutCycles)-1:0] silentCycles;
  logic                                            transactionActive;
  logic                                            timeoutPulse;

  // highest index wins.
  always_comb begin
    priorityGrant = '0;
    for (int i = 0; i < socBusPkg::nrOfMasters; i++) begin
      if (busRequests[i]) begin
        priorityGrant = '0;
        priorityGrant[i] = 1'b1;
      end
    end
  end

  always_ff @(posedge s_systemClock or negedge s_reset) begin
    if (!s_reset) begin
      busGrants <= '0;
      transactionActive <= 1'b0;
    end else if (sharedBus.endTransaction) begin
      busGrants <= '0;
      transactionActive <= 1'b0;
    end else if (sharedBus.beginTransaction) begin
      transactionActive <= 1'b1;
    end else if (!transactionActive) begin
      if (busGrants == '0) busGrants <= priorityGrant;
      else if ((busGrants & busRequests) == '0) busGrants <= '0; // owner gave up.
    end
  end

  // watchdog on silent transactions.
  always_ff @(posedge s_systemClock or negedge s_reset) begin
    if (!s_reset) begin
      silentCycles <= '0;
      timeoutPulse <= 1'b0;
    end else begin
      timeoutPulse <= 1'b0;
      if (sharedBus.beginTransaction || sharedBus.dataValid || sharedBus.endTransaction) begin
        silentCycles <= '0;
      end else if (transactionActive) begin
        silentCycles <= silentCycles + 1'b1;
        if (silentCycles == $bits(silentCycles)'(socBusPkg::busTimeoutCycles - 1))
          timeoutPulse <= 1'b1;
      end
    end
  end

  always_comb begin
    arbiterBus = '0;
    arbiterBus.busError = timeoutPulse;
    arbiterBus.endTransaction = timeoutPulse;
  end

endmodule

// File: rtl/busMemory.sv
`timescale 1ns/1ps

module busMemory (
  input  logic                   s_systemClock,
  input  logic                   s_reset,
  input  socBusPkg::busSignals_t sharedBus,
  output socBusPkg::busSignals_t memoryBus
);

  logic [31:0]                                  memoryArray [socBusPkg::memoryWords];
  logic [$clog2(socBusPkg::memoryWords)-1:0]    wordAddress;
  logic [7:0]                                   beatsLeft;
  logic [3:0]                                   byteEnables;
  logic [31:0]                                  readData;
  logic                                         claimed;
  logic                                         readActive;
  logic                                         writeActive;
  logic                                         beatValid;
  logic                                         lastBeat;
  logic                                         endPulse;

  assign claimed = sharedBus.beginTransaction &&
                   (sharedBus.addressData.address.region == 2'(socBusPkg::memoryRegion));

  always_ff @(posedge s_systemClock or negedge s_reset) begin
    if (!s_reset) begin
      readActive <= 1'b0;
      writeActive <= 1'b0;
      beatValid <= 1'b0;
      lastBeat <= 1'b0;
      endPulse <= 1'b0;
      wordAddress <= '0;
      beatsLeft <= '0;
      byteEnables <= '0;
    end else begin
      beatValid <= readActive;
      lastBeat <= readActive && (beatsLeft == 8'd0);
      endPulse <= lastBeat; // cycle after the last beat.
      if (claimed) begin
        readActive <= sharedBus.readNotWrite;
        writeActive <= ~sharedBus.readNotWrite;
        wordAddress <= sharedBus.addressData.address.wordOffset[$bits(wordAddress)-1:0];
        beatsLeft <= sharedBus.burstSize;
        byteEnables <= sharedBus.byteEnables;
      end else if (readActive) begin
        wordAddress <= wordAddress + 1'b1;
        beatsLeft <= beatsLeft - 1'b1;
        if (beatsLeft == 8'd0) readActive <= 1'b0;
      end else if (writeActive) begin
        if (sharedBus.dataValid) wordAddress <= wordAddress + 1'b1;
        if (sharedBus.endTransaction) writeActive <= 1'b0;
      end
    end
  end

  always_ff @(posedge s_systemClock) begin
    readData <= memoryArray[wordAddress];
    if (writeActive && sharedBus.dataValid) begin
      for (int b = 0; b < 4; b++) begin
        if (byteEnables[b])
          memoryArray[wordAddress][8*b +: 8] <= sharedBus.addressData.data[8*b +: 8];
      end
    end
  end

  always_comb begin
    memoryBus = '0;
    memoryBus.dataValid = beatValid;
    memoryBus.endTransaction = endPulse;
    if (beatValid) memoryBus.addressData.data = readData;
  end

endmodule

// File: rtl/gpioSlave.sv
`timescale 1ns/1ps

module gpioSlave (
  input  logic                   s_systemClock,
  input  logic                   s_reset,
  input  socBusPkg::busSignals_t sharedBus,
  output socBusPkg::busSignals_t gpioBus,
  input  logic [7:0]             dipSwitch,
  output logic [23:0]            sevenSegments
);

  logic [31:0] readData;
  logic [2:0]  byteEnables;
  logic        claimed;
  logic        readStage;
  logic        selectSegments;
  logic        writeActive;
  logic        beatValid;
  logic        endPulse;

  // single beats only.
  assign claimed = sharedBus.beginTransaction && (sharedBus.burstSize == 8'd0) &&
                   (sharedBus.addressData.address.region == 2'(socBusPkg::gpioRegion));

  always_ff @(posedge s_systemClock or negedge s_reset) begin
    if (!s_reset) begin
      readStage <= 1'b0;
      selectSegments <= 1'b0;
      writeActive <= 1'b0;
      beatValid <= 1'b0;
      endPulse <= 1'b0;
      byteEnables <= '0;
      sevenSegments <= '0;
    end else begin
      readStage <= claimed && sharedBus.readNotWrite &&
                   (sharedBus.addressData.address.wordOffset < 28'd2);
      beatValid <= readStage;
      endPulse <= beatValid;
      if (claimed) begin
        selectSegments <= (sharedBus.addressData.address.wordOffset == 28'd1);
        writeActive <= ~sharedBus.readNotWrite &&
                       (sharedBus.addressData.address.wordOffset == 28'd1);
        byteEnables <= sharedBus.byteEnables[2:0];
      end else if (sharedBus.endTransaction) begin
        writeActive <= 1'b0;
      end
      if (writeActive && sharedBus.dataValid) begin
        for (int b = 0; b < 3; b++) begin
          if (byteEnables[b]) sevenSegments[8*b +: 8] <= sharedBus.addressData.data[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge s_systemClock) begin
    readData <= selectSegments ? {8'd0, sevenSegments} : {24'd0, dipSwitch};
  end

  always_comb begin
    gpioBus = '0;
    gpioBus.dataValid = beatValid;
    gpioBus.endTransaction = endPulse;
    if (beatValid) gpioBus.addressData.data = readData;
  end

endmodule

// File: rtl/or1420Soc.sv
`timescale 1ns/1ps

module or1420Soc (
  input  logic                   s_systemClock,
  input  logic                   s_pllLocked,
  input  logic                   ciStart,
  input  logic [7:0]             ciN,
  input  logic [31:0]            ciDataA,
  input  logic [31:0]            ciDataB,
  output logic                   ciDone,
  output logic [31:0]            ciResult,
  input  logic                   cpuRequest,
  output logic                   cpuGrant,
  input  socBusPkg::busSignals_t cpuBus,
  output socBusPkg::busSignals_t sharedBus,
  input  logic [7:0]             dipSwitch,
  output logic [23:0]            sevenSegments
);

  logic [$clog2(socBusPkg::resetHoldCycles)-1:0] resetCount;
  logic                                          s_reset;
  logic [socBusPkg::nrOfMasters-1:0]             busRequests;
  logic [socBusPkg::nrOfMasters-1:0]             busGrants;
  logic                                          dmaRequest;
  socBusPkg::busSignals_t                        arbiterBus;
  socBusPkg::busSignals_t                        memoryBus;
  socBusPkg::busSignals_t                        gpioBus;
  socBusPkg::busSignals_t                        dmaBus;

  // internal reset stays low for the hold count after lock.
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      resetCount <= '0;
      s_reset <= 1'b0;
    end else begin
      if (!s_reset) resetCount <= resetCount + 1'b1;
      if (resetCount == $bits(resetCount)'(socBusPkg::resetHoldCycles - 1)) s_reset <= 1'b1;
    end
  end

  // idle agents drive zero.
  assign sharedBus = cpuBus | arbiterBus | memoryBus | gpioBus | dmaBus;

  assign busRequests = {cpuRequest, dmaRequest}; // processor first.
  assign cpuGrant = busGrants[1];

  busArbiter arbiter (
    .s_systemClock (s_systemClock),
    .s_reset       (s_reset),
    .busRequests   (busRequests),
    .busGrants     (busGrants),
    .sharedBus     (sharedBus),
    .arbiterBus    (arbiterBus)
  );

  busMemory memory (
    .s_systemClock (s_systemClock),
    .s_reset       (s_reset),
    .sharedBus     (sharedBus),
    .memoryBus     (memoryBus)
  );

  gpioSlave gpio (
    .s_systemClock (s_systemClock),
    .s_reset       (s_reset),
    .sharedBus     (sharedBus),
    .gpioBus       (gpioBus),
    .dipSwitch     (dipSwitch),
    .sevenSegments (sevenSegments)
  );

  ramDmaCi ramDma (
    .s_systemClock (s_systemClock),
    .s_reset       (s_reset),
    .ciStart       (ciStart),
    .ciN           (ciN),
    .ciDataA       (ciDataA),
    .ciDataB       (ciDataB),
    .ciDone        (ciDone),
    .ciResult      (ciResult),
    .busRequest    (dmaRequest),
    .busGrant      (busGrants[0]),
    .sharedBus     (sharedBus),
    .dmaBus        (dmaBus)
  );

endmodule

// File: rtl/ramDmaCi.sv
`timescale 1ns/1ps

module ramDmaCi (
  input  logic                   s_systemClock,
  input  logic                   s_reset,
  input  logic                   ciStart,
  input  logic [7:0]             ciN,
  input  logic [31:0]            ciDataA,
  input  logic [31:0]            ciDataB,
  output logic                   ciDone,
  output logic [31:0]            ciResult,
  output logic                   busRequest,
  input  logic                   busGrant,
  input  socBusPkg::busSignals_t sharedBus,
  output socBusPkg::busSignals_t dmaBus
);

  enum logic [2:0] {idleState, requestState, beginState, readState, writeState,
                    endState} dmaState;

  logic [31:0]           dmaBuffer [socBusPkg::dmaBufferWords];
  socBusPkg::ciCommand_t command;
  logic [31:0]           resultReg;
  logic [31:0]           startAddress;
  logic [31:0]           busAddress;
  logic [5:0]            transferLength;
  logic [5:0]            wordsLeft;
  logic [4:0]            bufferIndex;
  logic [3:0]            burstLeft;
  logic                  ciAccess;
  logic                  startRequest;
  logic                  toBus;
  logic                  errorFlag;
  logic                  dmaBusy;

  assign command = ciDataA;
  assign ciAccess = ciStart && (ciN == socBusPkg::ramDmaCiId);
  assign dmaBusy = (dmaState != idleState);
  assign startRequest = ciAccess && (command.select == 2'd3) && command.writeEnable &&
                        ciDataB[0] && (transferLength != 6'd0);
  assign busRequest = dmaBusy;
  assign ciResult = ciDone ? resultReg : 32'd0;

  always_ff @(posedge s_systemClock or negedge s_reset) begin
    if (!s_reset) begin
      dmaState <= idleState;
      ciDone <= 1'b0;
      startAddress <= '0;
      transferLength <= '0;
      busAddress <= '0;
      wordsLeft <= '0;
      bufferIndex <= '0;
      burstLeft <= '0;
      toBus <= 1'b0;
      errorFlag <= 1'b0;
    end else begin
      ciDone <= ciAccess;
      if (ciAccess && command.writeEnable) begin
        if (command.select == 2'd1) startAddress <= ciDataB;
        if (command.select == 2'd2) transferLength <= ciDataB[5:0];
      end
      case (dmaState)
        idleState : if (startRequest) begin
          dmaState <= requestState;
          toBus <= ciDataB[1];
          errorFlag <= 1'b0;
          busAddress <= startAddress;
          bufferIndex <= '0;
          wordsLeft <= transferLength;
        end
        requestState : if (busGrant) begin
          dmaState <= beginState;
          burstLeft <= (wordsLeft > 6'(socBusPkg::dmaBurstWords)) ?
                       4'(socBusPkg::dmaBurstWords) : wordsLeft[3:0];
        end
        beginState : dmaState <= toBus ? writeState : readState;
        readState : begin
          if (sharedBus.dataValid) begin
            bufferIndex <= bufferIndex + 1'b1;
            busAddress <= busAddress + 32'd4;
            wordsLeft <= wordsLeft - 1'b1;
          end
          if (sharedBus.endTransaction) begin
            if (sharedBus.busError) errorFlag <= 1'b1;
            dmaState <= (sharedBus.busError || wordsLeft == 6'd0) ? idleState : requestState;
          end
        end
        writeState : if (sharedBus.busError) begin
          errorFlag <= 1'b1;
          dmaState <= idleState;
        end else begin
          bufferIndex <= bufferIndex + 1'b1;
          busAddress <= busAddress + 32'd4;
          wordsLeft <= wordsLeft - 1'b1;
          burstLeft <= burstLeft - 1'b1;
          if (burstLeft == 4'd1) dmaState <= endState;
        end
        endState : dmaState <= (wordsLeft == 6'd0) ? idleState : requestState;
        default : dmaState <= idleState;
      endcase
    end
  end

  // result holds the old buffer word on a write.
  always_ff @(posedge s_systemClock) begin
    if (ciAccess) begin
      case (command.select)
        2'd0    : resultReg <= dmaBuffer[command.bufferIndex];
        2'd1    : resultReg <= startAddress;
        2'd2    : resultReg <= {26'd0, transferLength};
        default : resultReg <= {30'd0, errorFlag, dmaBusy};
      endcase
      if (command.select == 2'd0 && command.writeEnable)
        dmaBuffer[command.bufferIndex] <= ciDataB;
    end
    if (dmaState == readState && sharedBus.dataValid)
      dmaBuffer[bufferIndex] <= sharedBus.addressData.data;
  end

  always_comb begin
    dmaBus = '0;
    case (dmaState)
      beginState : begin
        dmaBus.beginTransaction = 1'b1;
        dmaBus.readNotWrite = ~toBus;
        dmaBus.byteEnables = 4'hF;
        dmaBus.burstSize = {4'd0, burstLeft - 4'd1};
        dmaBus.addressData.data = busAddress;
      end
      writeState : begin
        dmaBus.dataValid = 1'b1;
        dmaBus.addressData.data = dmaBuffer[bufferIndex];
      end
      endState : dmaBus.endTransaction = 1'b1;
      default : dmaBus = '0;
    endcase
  end

endmodule

// File: rtl/socBusPkg.sv
package socBusPkg;

  // address map with regions 2 and 3 unmapped.
  localparam int memoryRegion = 0;
  localparam int gpioRegion = 1;
  localparam int memoryWords = 1024;

  localparam logic [7:0] ramDmaCiId = 8'd20;
  localparam int dmaBufferWords = 32;
  localparam int dmaBurstWords = 8;

  localparam int busTimeoutCycles = 32;
  localparam int nrOfMasters = 2;
  localparam int resetHoldCycles = 16;

  typedef struct packed {
    logic [1:0]  region;
    logic [27:0] wordOffset;
    logic [1:0]  byteBits;
  } busAddress_t;

  // address phase or data phase view of the same word.
  typedef union packed {
    busAddress_t address;
    logic [31:0] data;
  } busWord_u;

  typedef struct packed {
    logic       beginTransaction;
    logic       endTransaction;
    logic       readNotWrite;
    logic       dataValid;
    logic       busError;
    logic [3:0] byteEnables;
    logic [7:0] burstSize;      // beats minus one.
    busWord_u   addressData;
  } busSignals_t;

  // ciDataA layout of the dma instruction.
  typedef struct packed {
    logic [23:0] unused;
    logic [1:0]  select;
    logic        writeEnable;
    logic [4:0]  bufferIndex;
  } ciCommand_t;

endpackage

// File: run.sh
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module socTb -o socTbSim
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
  echo "verilator build failed with status $buildStatus"
  exit 1
fi

./obj_dir/socTbSim
simStatus=$?
if [ $simStatus -ne 0 ]; then
  echo "simulation ended with status $simStatus"
  exit 1
fi

exit 0

// File: verif/busArbiter_assert.sv
`timescale 1ns/1ps

module busArbiterAssert (
  input logic                              s_systemClock,
  input logic                              s_reset,
  input logic [socBusPkg::nrOfMasters-1:0] busGrants,
  input socBusPkg::busSignals_t            sharedBus
);

  logic inTransaction;

  // open between begin and end.
  always_ff @(posedge s_systemClock or negedge s_reset) begin
    if (!s_reset) inTransaction <= 1'b0;
    else if (sharedBus.endTransaction) inTransaction <= 1'b0;
    else if (sharedBus.beginTransaction) inTransaction <= 1'b1;
  end

  singleGrant : assert property (@(posedge s_systemClock) disable iff (!s_reset)
    $onehot0(busGrants)) else $error("more than one bus grant is set");

  grantHeld : assert property (@(posedge s_systemClock) disable iff (!s_reset)
    (sharedBus.beginTransaction || inTransaction) && !sharedBus.endTransaction
      |=> $stable(busGrants)) else $error("bus grant changed inside a transaction");

  errorEnds : assert property (@(posedge s_systemClock) disable iff (!s_reset)
    sharedBus.busError |-> sharedBus.endTransaction)
    else $error("busError without endTransaction");

endmodule

bind busArbiter busArbiterAssert arbiterChecks (.*);

// File: verif/socTb.sv
`timescale 1ns/1ps

module socTb;

  localparam int waitLimit = 200;

  logic                   s_systemClock;
  logic                   s_pllLocked;
  logic                   ciStart;
  logic [7:0]             ciN;
  logic [31:0]            ciDataA;
  logic [31:0]            ciDataB;
  logic                   ciDone;
  logic [31:0]            ciResult;
  logic                   cpuRequest;
  logic                   cpuGrant;
  socBusPkg::busSignals_t cpuBus;
  socBusPkg::busSignals_t sharedBus;
  logic [7:0]             dipSwitch;
  logic [23:0]            sevenSegments;

  integer      randomSeed;
  logic [31:0] writeWords [$];
  logic [31:0] readWords [$];
  logic        endWithError;

  or1420Soc UUT (.*);

  initial s_systemClock = 1'b0;
  always #4 s_systemClock = ~s_systemClock;

  task automatic failRun(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected)
      failRun($sformatf("mismatch %s: got 0x%08h, expected 0x%08h", name, actual, expected));
  endtask

  function automatic socBusPkg::busAddress_t regionAddress(input logic [1:0] region,
                                                           input logic [27:0] offset);
    socBusPkg::busAddress_t address;
    address.region = region;
    address.wordOffset = offset;
    address.byteBits = 2'd0;
    return address;
  endfunction

  task automatic waitGrant();
    int cycles;
    cycles = 0;
    do begin
      @(negedge s_systemClock);
      cycles++;
      if (cycles > waitLimit) failRun("timeout waiting for the processor bus grant");
    end while (!cpuGrant);
  endtask

  // beats come from writeWords.
  task automatic cpuWrite(input logic [1:0] region, input logic [27:0] offset,
                          input logic [3:0] byteEnables);
    socBusPkg::busSignals_t beat;
    @(posedge s_systemClock);
    cpuRequest <= 1'b1;
    waitGrant();
    beat = '0;
    beat.beginTransaction = 1'b1;
    beat.byteEnables = byteEnables;
    beat.burstSize = 8'(writeWords.size() - 1);
    beat.addressData.address = regionAddress(region, offset);
    @(posedge s_systemClock);
    cpuBus <= beat;
    cpuRequest <= 1'b0; // grant is held by the transaction now.
    foreach (writeWords[i]) begin
      beat = '0;
      beat.dataValid = 1'b1;
      beat.addressData.data = writeWords[i];
      @(posedge s_systemClock);
      cpuBus <= beat;
    end
    beat = '0;
    beat.endTransaction = 1'b1;
    @(posedge s_systemClock);
    cpuBus <= beat;
    @(posedge s_systemClock);
    cpuBus <= '0;
  endtask

  // beats land in readWords.
  task automatic cpuRead(input logic [1:0] region, input logic [27:0] offset, input int beats);
    socBusPkg::busSignals_t beat;
    int cycles;
    @(posedge s_systemClock);
    cpuRequest <= 1'b1;
    waitGrant();
    beat = '0;
    beat.beginTransaction = 1'b1;
    beat.readNotWrite = 1'b1;
    beat.byteEnables = 4'hF;
    beat.burstSize = 8'(beats - 1);
    beat.addressData.address = regionAddress(region, offset);
    @(posedge s_systemClock);
    cpuBus <= beat;
    cpuRequest <= 1'b0;
    @(posedge s_systemClock);
    cpuBus <= '0;
    readWords.delete();
    endWithError = 1'b0;
    cycles = 0;
    do begin
      @(negedge s_systemClock);
      if (sharedBus.dataValid) readWords.push_back(sharedBus.addressData.data);
      endWithError = sharedBus.busError && sharedBus.endTransaction;
      cycles++;
      if (cycles > waitLimit) failRun("timeout waiting for the end of a processor read");
    end while (!sharedBus.endTransaction);
  endtask

  task automatic ciCall(input logic [1:0] select, input logic writeEnable,
                        input logic [4:0] index, input logic [31:0] dataB,
                        output logic [31:0] result);
    socBusPkg::ciCommand_t command;
    command = '0;
    command.select = select;
    command.writeEnable = writeEnable;
    command.bufferIndex = index;
    @(posedge s_systemClock);
    ciStart <= 1'b1;
    ciN <= socBusPkg::ramDmaCiId;
    ciDataA <= command;
    ciDataB <= dataB;
    @(negedge s_systemClock);
    checkValue("ciDone in the start cycle", 32'(ciDone), 32'd0);
    checkValue("ciResult in the start cycle", ciResult, 32'd0);
    @(posedge s_systemClock);
    ciStart <= 1'b0;
    ciN <= 8'd0;
    ciDataA <= 32'd0;
    ciDataB <= 32'd0;
    @(negedge s_systemClock);
    checkValue("ciDone one cycle after start", 32'(ciDone), 32'd1);
    result = ciResult;
  endtask

  task automatic waitDmaIdle(output logic [31:0] status);
    int polls;
    polls = 0;
    do begin
      ciCall(2'd3, 1'b0, 5'd0, 32'd0, status);
      polls++;
      if (polls > waitLimit) failRun("timeout waiting for the DMA transfer to finish");
    end while (status[0]);
  endtask

  task automatic memoryBurstTest();
    writeWords.delete();
    repeat (4) writeWords.push_back($random(randomSeed));
    cpuWrite(2'd0, 28'h10, 4'hF);
    cpuRead(2'd0, 28'h10, 4);
    checkValue("burst read beats", 32'(readWords.size()), 32'd4);
    foreach (writeWords[i]) checkValue("burst read data", readWords[i], writeWords[i]);
  endtask

  task automatic gpioTest();
    logic [31:0] original;
    logic [31:0] update;
    logic [31:0] expected;
    logic [7:0]  dipValue;
    writeWords.delete();
    writeWords.push_back($random(randomSeed));
    expected = writeWords[0];
    cpuWrite(2'd1, 28'd1, 4'hF);
    @(negedge s_systemClock);
    checkValue("sevenSegments", {8'd0, sevenSegments}, {8'd0, expected[23:0]});
    dipValue = 8'($random(randomSeed));
    @(posedge s_systemClock);
    dipSwitch <= dipValue;
    cpuRead(2'd1, 28'd0, 1);
    checkValue("dip switch read beats", 32'(readWords.size()), 32'd1);
    checkValue("dip switch read", readWords[0], {24'd0, dipValue});
    original = $random(randomSeed);
    update = $random(randomSeed);
    writeWords.delete();
    writeWords.push_back(original);
    cpuWrite(2'd0, 28'h20, 4'hF);
    writeWords.delete();
    writeWords.push_back(update);
    cpuWrite(2'd0, 28'h20, 4'b0101);
    expected = {original[31:24], update[23:16], original[15:8], update[7:0]};
    cpuRead(2'd0, 28'h20, 1);
    checkValue("byte enabled write", readWords[0], expected);
  endtask

  task automatic dmaToBusTest();
    logic [31:0] bufferWords [$];
    logic [31:0] result;
    logic [31:0] word;
    for (int i = 0; i < 12; i++) begin
      word = $random(randomSeed);
      bufferWords.push_back(word);
      ciCall(2'd0, 1'b1, 5'(i), word, result);
    end
    ciCall(2'd1, 1'b1, 5'd0, 32'h0000_0400, result); // word offset 0x100.
    ciCall(2'd1, 1'b0, 5'd0, 32'd0, result);
    checkValue("dma start address", result, 32'h0000_0400);
    ciCall(2'd2, 1'b1, 5'd0, 32'd12, result);
    ciCall(2'd2, 1'b0, 5'd0, 32'd0, result);
    checkValue("dma transfer length", result, 32'd12);
    ciCall(2'd3, 1'b1, 5'd0, 32'h3, result);
    waitDmaIdle(result);
    checkValue("dma status after buffer-to-bus", result, 32'd0);
    cpuRead(2'd0, 28'h100, 12);
    checkValue("dma copy read beats", 32'(readWords.size()), 32'd12);
    foreach (bufferWords[i]) checkValue("memory after dma", readWords[i], bufferWords[i]);
    // old word comes back on a buffer write.
    ciCall(2'd0, 1'b1, 5'd0, ~bufferWords[0], result);
    checkValue("buffer word before write", result, bufferWords[0]);
  endtask

  task automatic dmaFromBusTest();
    logic [31:0] result;
    logic [31:0] status;
    int          polls;
    writeWords.delete();
    repeat (16) writeWords.push_back($random(randomSeed));
    cpuWrite(2'd0, 28'h180, 4'hF);
    ciCall(2'd1, 1'b1, 5'd0, 32'h0000_0600, result);
    ciCall(2'd2, 1'b1, 5'd0, 32'd16, result);
    ciCall(2'd3, 1'b1, 5'd0, 32'h1, result);
    status = 32'd1;
    polls = 0;
    while (status[0]) begin
      cpuRead(2'd0, 28'h180 + 28'(polls % 16), 1); // competes with the engine.
      checkValue("contended read beats", 32'(readWords.size()), 32'd1);
      checkValue("contended read data", readWords[0], writeWords[polls % 16]);
      ciCall(2'd3, 1'b0, 5'd0, 32'd0, status);
      polls++;
      if (polls > waitLimit) failRun("timeout waiting for the contended DMA transfer to finish");
    end
    checkValue("dma error flag after bus-to-buffer", {31'd0, status[1]}, 32'd0);
    for (int i = 0; i < 16; i++) begin
      ciCall(2'd0, 1'b0, 5'(i), 32'd0, result);
      checkValue("buffer after dma", result, writeWords[i]);
    end
  endtask

  task automatic unmappedTest();
    logic [31:0] result;
    cpuRead(2'd3, 28'h0, 1);
    checkValue("data beats from unmapped region", 32'(readWords.size()), 32'd0);
    checkValue("busError with endTransaction", {31'd0, endWithError}, 32'd1);
    ciCall(2'd1, 1'b1, 5'd0, 32'h8000_0000, result); // region 2.
    ciCall(2'd2, 1'b1, 5'd0, 32'd4, result);
    ciCall(2'd3, 1'b1, 5'd0, 32'h1, result);
    waitDmaIdle(result);
    checkValue("dma status after unmapped transfer", result, 32'h2);
  endtask

  initial begin
    logic [31:0] status;
    randomSeed = 32'h40bb_d241;
    s_pllLocked = 1'b0;
    ciStart = 1'b0;
    ciN = 8'd0;
    ciDataA = 32'd0;
    ciDataB = 32'd0;
    cpuRequest = 1'b0;
    cpuBus = '0;
    dipSwitch = 8'd0;
    repeat (8) @(posedge s_systemClock);
    s_pllLocked <= 1'b1;
    repeat (socBusPkg::resetHoldCycles + 2) @(posedge s_systemClock);
    @(negedge s_systemClock);
    checkValue("cpuGrant after reset", 32'(cpuGrant), 32'd0);
    checkValue("ciDone after reset", 32'(ciDone), 32'd0);
    checkValue("sevenSegments after reset", {8'd0, sevenSegments}, 32'd0);
    checkValue("sharedBus busy after reset", 32'(sharedBus != '0), 32'd0);
    ciCall(2'd3, 1'b0, 5'd0, 32'd0, status);
    checkValue("dma status after reset", status, 32'd0);
    memoryBurstTest();
    gpioTest();
    dmaToBusTest();
    dmaFromBusTest();
    unmappedTest();
    $display("TEST PASSED");
    $finish;
  end

endmodule
